//--- Bender.yml
package:
  name: fb_tile

sources:
  - files:
      - design/fb_pkg.sv
      - design/fb_cmd_decoder.sv
      - design/fb_lane.sv
      - design/fb_scanout.sv
      - design/fb_tile_top.sv
  - target: test
    files:
      - tb/fb_tile_checker.sv
      - tb/tb_fb_tile.sv

//--- all.f
design/fb_pkg.sv
design/fb_cmd_decoder.sv
design/fb_lane.sv
design/fb_scanout.sv
design/fb_tile_top.sv
tb/fb_tile_checker.sv
tb/tb_fb_tile.sv

//--- design/fb_cmd_decoder.sv
/*
 * Command stream decoder. A fragment takes two words, all other commands one.
 * Clear and readback stall the stream until the lanes are idle or the readback
 * handshake is done. Commands for lane 3 and unknown opcodes are dropped.
 */
module fb_cmd_decoder (
    input  logic                                           aclk,
    input  logic                                           rst_n,
    input  logic                                           cmd_valid,
    output logic                                           cmd_ready,
    input  fb_pkg::cmd_word_t                              cmd_data,
    output fb_pkg::lane_config_t [fb_pkg::LANE_COUNT-1:0]  lane_config,
    output fb_pkg::scissor_t                               scissor,
    output fb_pkg::lane_op_t [fb_pkg::LANE_COUNT-1:0]      lane_op,
    input  logic [fb_pkg::LANE_COUNT-1:0]                  lane_busy,
    output logic                                           rb_req,
    output fb_pkg::lane_sel_t                              rb_lane,
    input  logic                                           rb_ack
);
    typedef enum logic [1:0] {IDLE, FRAG_DATA, WAIT_CLEAR, WAIT_READBACK} state_e;

    state_e                           state;
    logic                             accept;
    logic                             lane_ok;
    fb_pkg::cmd_op_e                  opcode;
    fb_pkg::lane_sel_t                cmd_lane;
    logic                             op_write;
    logic [fb_pkg::LANE_COUNT-1:0]    op_clear;
    fb_pkg::tile_x_t                  frag_x;
    fb_pkg::tile_y_t                  frag_y;
    logic [fb_pkg::STENCIL_BITS-1:0]  frag_stencil;
    fb_pkg::pixel_t                   frag_color;
    fb_pkg::pixel_t                   frag_depth;

    assign accept   = cmd_valid && cmd_ready;
    assign opcode   = fb_pkg::cmd_op_e'(cmd_data[31:28]);
    assign cmd_lane = cmd_data[27:26];
    assign lane_ok  = cmd_lane < fb_pkg::lane_sel_t'(fb_pkg::LANE_COUNT);

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state       <= IDLE;
            cmd_ready   <= 1'b0;
            lane_config <= '0;
            scissor     <= '0;
            op_write    <= 1'b0;
            op_clear    <= '0;
            rb_req      <= 1'b0;
            rb_lane     <= '0;
        end
        else
        begin
            op_write <= 1'b0;
            op_clear <= '0;
            case (state)
                IDLE:
                begin
                    cmd_ready <= 1'b1;
                    if (accept)
                    begin
                        case (opcode)
                            fb_pkg::OP_CONFIG:
                            begin
                                if (lane_ok)
                                begin
                                    lane_config[cmd_lane].enable <= cmd_data[24];
                                    lane_config[cmd_lane].mask   <= cmd_data[15:0];
                                end
                            end
                            fb_pkg::OP_CLEAR_VALUE:
                            begin
                                if (lane_ok)
                                    lane_config[cmd_lane].clear_value <= cmd_data[15:0];
                            end
                            fb_pkg::OP_SCISSOR:
                                scissor <= {cmd_data[24], cmd_data[4:0], cmd_data[8:5],
                                            cmd_data[13:9], cmd_data[17:14]};
                            fb_pkg::OP_CLEAR:
                            begin
                                op_clear  <= cmd_data[fb_pkg::LANE_COUNT-1:0];
                                cmd_ready <= 1'b0;
                                state     <= WAIT_CLEAR;
                            end
                            fb_pkg::OP_FRAGMENT:
                                state <= FRAG_DATA;
                            fb_pkg::OP_READBACK:
                            begin
                                if (lane_ok)
                                begin
                                    rb_lane   <= cmd_lane;
                                    rb_req    <= 1'b1;
                                    cmd_ready <= 1'b0;
                                    state     <= WAIT_READBACK;
                                end
                            end
                            default:
                                state <= IDLE;
                        endcase
                    end
                end
                FRAG_DATA:
                begin
                    if (accept)
                    begin
                        op_write <= 1'b1;
                        state    <= IDLE;
                    end
                end
                WAIT_CLEAR:
                begin
                    // Strobes still in flight count as busy until the lanes report it
                    if (op_clear == '0 && lane_busy == '0)
                    begin
                        cmd_ready <= 1'b1;
                        state     <= IDLE;
                    end
                end
                WAIT_READBACK:
                begin
                    if (rb_req && rb_ack)
                        rb_req <= 1'b0;
                    else if (!rb_req && !rb_ack)
                    begin
                        cmd_ready <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (accept && state == IDLE && opcode == fb_pkg::OP_FRAGMENT)
        begin
            frag_x       <= cmd_data[4:0];
            frag_y       <= cmd_data[8:5];
            frag_stencil <= cmd_data[19:16];
        end
        if (accept && state == FRAG_DATA)
        begin
            frag_color <= cmd_data[31:16];
            frag_depth <= cmd_data[15:0];
        end
    end

    always_comb
    begin
        for (int i = 0; i < fb_pkg::LANE_COUNT; i++)
        begin
            lane_op[i].write = op_write;
            lane_op[i].clear = op_clear[i];
            lane_op[i].x     = frag_x;
            lane_op[i].y     = frag_y;
            if (i == fb_pkg::LANE_COLOR)
                lane_op[i].data = frag_color;
            else if (i == fb_pkg::LANE_DEPTH)
                lane_op[i].data = frag_depth;
            else if (i == fb_pkg::LANE_STENCIL)
                lane_op[i].data = fb_pkg::pixel_t'(frag_stencil);
            else
                lane_op[i].data = '0;
        end
    end

endmodule

//--- design/fb_lane.sv
/*
 * One tile buffer lane. Writes merge old and new data under the lane mask and
 * are dropped when the lane is disabled or outside an enabled scissor rectangle.
 * A clear runs for TILE_PIXELS cycles with busy high. Readback is asynchronous.
 */
module fb_lane (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  fb_pkg::lane_config_t  conf,
    input  fb_pkg::scissor_t      scissor,
    input  fb_pkg::lane_op_t      op,
    output logic                  busy,
    input  fb_pkg::pixel_index_t  read_index,
    output fb_pkg::pixel_t        read_data
);
    fb_pkg::pixel_t        tile [fb_pkg::TILE_PIXELS];
    fb_pkg::pixel_index_t  clear_index;
    fb_pkg::tile_x_t       wr_x;
    fb_pkg::tile_y_t       wr_y;
    fb_pkg::pixel_index_t  wr_index;
    fb_pkg::pixel_t        wr_data;
    logic                  in_scissor;
    logic                  wr_en;

    // The clear sequencer owns the write port while it runs
    always_comb
    begin
        if (busy)
        begin
            wr_x    = clear_index[fb_pkg::TILE_X_BITS-1:0];
            wr_y    = clear_index[fb_pkg::TILE_X_BITS +: fb_pkg::TILE_Y_BITS];
            wr_data = conf.clear_value;
        end
        else
        begin
            wr_x    = op.x;
            wr_y    = op.y;
            wr_data = op.data;
        end
    end

    assign wr_index   = {wr_y, wr_x};
    assign in_scissor = !scissor.enable
                        || (wr_x >= scissor.start_x && wr_x <= scissor.end_x
                            && wr_y >= scissor.start_y && wr_y <= scissor.end_y);
    assign wr_en      = conf.enable && in_scissor && (busy || op.write);

    always_ff @(posedge aclk)
    begin
        if (wr_en)
            tile[wr_index] <= (wr_data & conf.mask) | (tile[wr_index] & ~conf.mask);
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            busy        <= 1'b0;
            clear_index <= '0;
        end
        else if (busy)
        begin
            clear_index <= clear_index + 1'b1;
            if (clear_index == fb_pkg::pixel_index_t'(fb_pkg::TILE_PIXELS - 1))
                busy <= 1'b0;
        end
        else if (op.clear)
        begin
            busy        <= 1'b1;
            clear_index <= '0;
        end
    end

    assign read_data = tile[read_index];

endmodule

//--- design/fb_pkg.sv
/*
 * Shared definitions for the tile framebuffer.
 * One tile is 32 x 16 pixels, stored per lane as 16-bit words in raster order.
 * Stencil values are 4 bits wide and are stored zero-extended.
 */
package fb_pkg;

    localparam int TILE_X_BITS  = 5;
    localparam int TILE_Y_BITS  = 4;
    localparam int TILE_PIXELS  = 512;
    localparam int LANE_COUNT   = 3;
    localparam int PIXEL_BITS   = 16;
    localparam int STENCIL_BITS = 4;
    localparam int CMD_BITS     = 32;

    typedef logic [CMD_BITS-1:0]                  cmd_word_t;
    typedef logic [PIXEL_BITS-1:0]                pixel_t;
    typedef logic [TILE_X_BITS-1:0]               tile_x_t;
    typedef logic [TILE_Y_BITS-1:0]               tile_y_t;
    typedef logic [TILE_X_BITS+TILE_Y_BITS-1:0]   pixel_index_t;
    typedef logic [1:0]                           lane_sel_t;

    localparam lane_sel_t LANE_COLOR   = 2'd0;
    localparam lane_sel_t LANE_DEPTH   = 2'd1;
    localparam lane_sel_t LANE_STENCIL = 2'd2;

    // Opcode in bits 31..28 of the first command word
    typedef enum logic [3:0] {
        OP_CONFIG      = 4'd1,
        OP_CLEAR_VALUE = 4'd2,
        OP_SCISSOR     = 4'd3,
        OP_CLEAR       = 4'd4,
        OP_FRAGMENT    = 4'd5,
        OP_READBACK    = 4'd6
    } cmd_op_e;

    typedef struct packed {
        logic   enable;
        pixel_t mask;
        pixel_t clear_value;
    } lane_config_t;

    // Bounds are inclusive on both ends
    typedef struct packed {
        logic    enable;
        tile_x_t start_x;
        tile_y_t start_y;
        tile_x_t end_x;
        tile_y_t end_y;
    } scissor_t;

    typedef struct packed {
        logic    write;
        logic    clear;
        tile_x_t x;
        tile_y_t y;
        pixel_t  data;
    } lane_op_t;

endpackage

//--- design/fb_scanout.sv
/*
 * Streams one lane's tile in raster order through a single output register.
 * fb_last marks pixel 511. A color readback runs the four-phase swap handshake
 * before the readback request is acknowledged.
 */
module fb_scanout (
    input  logic                                     aclk,
    input  logic                                     rst_n,
    input  logic                                     rb_req,
    input  fb_pkg::lane_sel_t                        rb_lane,
    output logic                                     rb_ack,
    output fb_pkg::pixel_index_t                     read_index,
    input  fb_pkg::pixel_t [fb_pkg::LANE_COUNT-1:0]  lane_data,
    output logic                                     fb_valid,
    input  logic                                     fb_ready,
    output logic                                     fb_last,
    output fb_pkg::pixel_t                           fb_data,
    output logic                                     swap_fb,
    input  logic                                     fb_swapped
);
    typedef enum logic [2:0] {IDLE, STREAM, SWAP_REQ, SWAP_RELEASE, ACK} state_e;

    state_e  state;
    logic    load_beat;

    // Output stage takes a pixel when empty or drained and never past the last one
    assign load_beat = (state == STREAM) && (!fb_valid || fb_ready) && !(fb_valid && fb_last);

    always_ff @(posedge aclk)
    begin
        if (load_beat)
            fb_data <= lane_data[rb_lane];
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            state      <= IDLE;
            read_index <= '0;
            fb_valid   <= 1'b0;
            fb_last    <= 1'b0;
            swap_fb    <= 1'b0;
            rb_ack     <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (rb_req && !rb_ack)
                    begin
                        read_index <= '0;
                        state      <= STREAM;
                    end
                end
                STREAM:
                begin
                    if (load_beat)
                    begin
                        fb_valid   <= 1'b1;
                        fb_last    <= read_index
                                      == fb_pkg::pixel_index_t'(fb_pkg::TILE_PIXELS - 1);
                        read_index <= read_index + 1'b1;
                    end
                    else if (fb_valid && fb_last && fb_ready)
                    begin
                        fb_valid <= 1'b0;
                        fb_last  <= 1'b0;
                        if (rb_lane == fb_pkg::LANE_COLOR)
                        begin
                            swap_fb <= 1'b1;
                            state   <= SWAP_REQ;
                        end
                        else
                        begin
                            rb_ack <= 1'b1;
                            state  <= ACK;
                        end
                    end
                end
                SWAP_REQ:
                begin
                    if (fb_swapped)
                    begin
                        swap_fb <= 1'b0;
                        state   <= SWAP_RELEASE;
                    end
                end
                SWAP_RELEASE:
                begin
                    if (!fb_swapped)
                    begin
                        rb_ack <= 1'b1;
                        state  <= ACK;
                    end
                end
                ACK:
                begin
                    if (!rb_req)
                    begin
                        rb_ack <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

//--- design/fb_tile_top.sv
/*
 * Tile framebuffer top level with color, depth and stencil lanes on chip.
 * Tile contents are undefined after reset until a clear has run.
 */
module fb_tile_top (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  fb_pkg::cmd_word_t  cmd_data,
    output logic               fb_valid,
    input  logic               fb_ready,
    output logic               fb_last,
    output fb_pkg::pixel_t     fb_data,
    output logic               swap_fb,
    input  logic               fb_swapped
);
    fb_pkg::lane_config_t [fb_pkg::LANE_COUNT-1:0]  lane_config;
    fb_pkg::lane_op_t [fb_pkg::LANE_COUNT-1:0]      lane_op;
    fb_pkg::pixel_t [fb_pkg::LANE_COUNT-1:0]        lane_data;
    logic [fb_pkg::LANE_COUNT-1:0]                  lane_busy;
    fb_pkg::scissor_t                               scissor;
    fb_pkg::pixel_index_t                           read_index;
    fb_pkg::lane_sel_t                              rb_lane;
    logic                                           rb_req;
    logic                                           rb_ack;

    fb_cmd_decoder decoder (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_data    (cmd_data),
        .lane_config (lane_config),
        .scissor     (scissor),
        .lane_op     (lane_op),
        .lane_busy   (lane_busy),
        .rb_req      (rb_req),
        .rb_lane     (rb_lane),
        .rb_ack      (rb_ack)
    );

    // Lane i follows the fb_pkg numbering of color, depth and stencil
    for (genvar i = 0; i < fb_pkg::LANE_COUNT; i++)
    begin : g_lane
        fb_lane lane (
            .aclk       (aclk),
            .rst_n      (rst_n),
            .conf       (lane_config[i]),
            .scissor    (scissor),
            .op         (lane_op[i]),
            .busy       (lane_busy[i]),
            .read_index (read_index),
            .read_data  (lane_data[i])
        );
    end

    fb_scanout scanout (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .rb_req     (rb_req),
        .rb_lane    (rb_lane),
        .rb_ack     (rb_ack),
        .read_index (read_index),
        .lane_data  (lane_data),
        .fb_valid   (fb_valid),
        .fb_ready   (fb_ready),
        .fb_last    (fb_last),
        .fb_data    (fb_data),
        .swap_fb    (swap_fb),
        .fb_swapped (fb_swapped)
    );

endmodule

//--- tb/fb_tile_checker.sv
/*
 * Protocol assertions on the framebuffer top level, attached with bind.
 * All checks except the reset check are disabled while rst_n is low.
 */
module fb_tile_checker (
    input logic            aclk,
    input logic            rst_n,
    input logic            cmd_ready,
    input logic            fb_valid,
    input logic            fb_ready,
    input fb_pkg::pixel_t  fb_data,
    input logic            swap_fb,
    input logic            fb_swapped
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    // A stalled beat keeps its valid and data
    stalled_beat_holds: assert property (@(posedge aclk) disable iff (!rst_n)
        fb_valid && !fb_ready |=> fb_valid && $stable(fb_data))
    else
    begin
        failures++;
        $error("fb_valid or fb_data changed while fb_ready was low");
    end

    swap_held: assert property (@(posedge aclk) disable iff (!rst_n)
        swap_fb && !fb_swapped |=> swap_fb)
    else
    begin
        failures++;
        $error("swap_fb dropped before fb_swapped was seen");
    end

    no_cmd_during_swap: assert property (@(posedge aclk) disable iff (!rst_n)
        swap_fb |-> !cmd_ready)
    else
    begin
        failures++;
        $error("cmd_ready high during a swap request");
    end

    quiet_in_reset: assert property (@(posedge aclk)
        !rst_n |=> !fb_valid && !swap_fb)
    else
    begin
        failures++;
        $error("fb_valid or swap_fb high during reset");
    end

endmodule

bind fb_tile_top fb_tile_checker checks (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .cmd_ready  (cmd_ready),
    .fb_valid   (fb_valid),
    .fb_ready   (fb_ready),
    .fb_data    (fb_data),
    .swap_fb    (swap_fb),
    .fb_swapped (fb_swapped)
);

//--- tb/tb_fb_tile.sv
/*
 * Testbench for the tile framebuffer with a reference model of all three tiles.
 * Tiles are undefined after reset, so the run starts with a full clear.
 * fb_ready and the swap responder are driven randomly from one fixed seed.
 */
module tb_fb_tile;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 20;
    localparam int SEED            = 32'h62e07f87;
    localparam int FRAG_ROUNDS     = 4;
    localparam int FRAGS_PER_ROUND = 24;
    localparam int SCISSOR_ROUNDS  = 3;
    localparam int SCISSOR_FRAGS   = 32;
    // Command words over the whole run with two per readback
    localparam int CMD_COUNT   = 21 + FRAG_ROUNDS * (5 + 2 * FRAGS_PER_ROUND) + 6
                                 + SCISSOR_ROUNDS * (14 + 2 * SCISSOR_FRAGS);
    localparam int WATCHDOG_NS = CMD_COUNT * (fb_pkg::TILE_PIXELS + 64) * CLK_PERIOD;

    logic               aclk;
    logic               rst_n;
    logic               cmd_valid;
    logic               cmd_ready;
    fb_pkg::cmd_word_t  cmd_data;
    logic               fb_valid;
    logic               fb_ready;
    logic               fb_last;
    fb_pkg::pixel_t     fb_data;
    logic               swap_fb;
    logic               fb_swapped;

    fb_pkg::pixel_t        model_tile [fb_pkg::LANE_COUNT][fb_pkg::TILE_PIXELS];
    fb_pkg::lane_config_t  model_cfg [fb_pkg::LANE_COUNT];
    fb_pkg::scissor_t      model_scissor;
    fb_pkg::lane_sel_t     expect_lane;
    logic                  rb_active = 1'b0;
    int                    beat_count = 0;
    int                    last_count = 0;
    int                    swap_count = 0;
    int                    pixel_errors = 0;
    int                    last_errors = 0;
    int                    protocol_errors = 0;

    fb_tile_top UUT (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_data   (cmd_data),
        .fb_valid   (fb_valid),
        .fb_ready   (fb_ready),
        .fb_last    (fb_last),
        .fb_data    (fb_data),
        .swap_fb    (swap_fb),
        .fb_swapped (fb_swapped)
    );

    initial
    begin
        aclk = 1'b0;
        forever
            #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    task automatic check_pixel(input fb_pkg::pixel_t expected, input fb_pkg::pixel_t got,
                               input fb_pkg::pixel_index_t index);
        if (got !== expected)
        begin
            pixel_errors++;
            $display("Error %0t: lane %0d pixel %0d expected %h got %h",
                     $time, expect_lane, index, expected, got);
        end
    endtask

    task automatic check_last(input fb_pkg::pixel_index_t index);
        if (index != fb_pkg::pixel_index_t'(fb_pkg::TILE_PIXELS - 1))
        begin
            last_errors++;
            $display("Error %0t: fb_last on beat %0d of lane %0d", $time, index, expect_lane);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int got);
        if (got != expected)
        begin
            protocol_errors++;
            $display("Error %0t: lane %0d %s expected %0d got %0d",
                     $time, expect_lane, what, expected, got);
        end
    endtask

    function automatic logic inside_scissor(input fb_pkg::tile_x_t x, input fb_pkg::tile_y_t y);
        if (!model_scissor.enable)
            return 1'b1;
        return x >= model_scissor.start_x && x <= model_scissor.end_x
               && y >= model_scissor.start_y && y <= model_scissor.end_y;
    endfunction

    // Mask bits take the new data and the others keep the stored word
    task automatic model_store(input int lane, input fb_pkg::pixel_index_t index,
                               input fb_pkg::pixel_t data);
        fb_pkg::pixel_t mask;
        mask = model_cfg[lane].mask;
        if (model_cfg[lane].enable && inside_scissor(index[4:0], index[8:5]))
            model_tile[lane][index] = (data & mask) | (model_tile[lane][index] & ~mask);
    endtask

    task automatic send_word(input fb_pkg::cmd_word_t word);
        cmd_valid = 1'b1;
        cmd_data  = word;
        @(posedge aclk);
        while (!cmd_ready)
            @(posedge aclk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic set_config(input fb_pkg::lane_sel_t lane, input logic enable,
                              input fb_pkg::pixel_t mask);
        send_word({fb_pkg::OP_CONFIG, lane, 1'b0, enable, 8'h00, mask});
        model_cfg[lane].enable = enable;
        model_cfg[lane].mask   = mask;
    endtask

    task automatic set_clear_value(input fb_pkg::lane_sel_t lane, input fb_pkg::pixel_t value);
        send_word({fb_pkg::OP_CLEAR_VALUE, lane, 10'd0, value});
        model_cfg[lane].clear_value = value;
    endtask

    task automatic set_scissor(input fb_pkg::scissor_t sc);
        send_word({fb_pkg::OP_SCISSOR, 3'd0, sc.enable, 6'd0,
                   sc.end_y, sc.end_x, sc.start_y, sc.start_x});
        model_scissor = sc;
    endtask

    task automatic clear_lanes(input logic [2:0] lanes);
        send_word({fb_pkg::OP_CLEAR, 25'd0, lanes});
        for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
        begin
            if (lanes[l])
            begin
                for (int i = 0; i < fb_pkg::TILE_PIXELS; i++)
                    model_store(l, fb_pkg::pixel_index_t'(i), model_cfg[l].clear_value);
            end
        end
    endtask

    task automatic write_fragment(input fb_pkg::tile_x_t x, input fb_pkg::tile_y_t y,
                                  input logic [3:0] stencil, input fb_pkg::pixel_t color,
                                  input fb_pkg::pixel_t depth);
        send_word({fb_pkg::OP_FRAGMENT, 8'h00, stencil, 7'h00, y, x});
        send_word({color, depth});
        model_store(fb_pkg::LANE_COLOR, {y, x}, color);
        model_store(fb_pkg::LANE_DEPTH, {y, x}, depth);
        model_store(fb_pkg::LANE_STENCIL, {y, x}, {12'h000, stencil});
    endtask

    // A spare word waits behind the readback and must not pass before it completes
    task automatic read_lane(input fb_pkg::lane_sel_t lane);
        int swaps_before;
        swaps_before = swap_count;
        expect_lane  = lane;
        beat_count   = 0;
        last_count   = 0;
        rb_active    = 1'b1;
        send_word({fb_pkg::OP_READBACK, lane, 26'd0});
        send_word({4'hf, 28'd0});
        rb_active = 1'b0;
        check_count("beats", fb_pkg::TILE_PIXELS, beat_count);
        check_count("last flags", 1, last_count);
        check_count("swap handshakes", (lane == fb_pkg::LANE_COLOR) ? 1 : 0,
                    swap_count - swaps_before);
    endtask

    task automatic drive_ready();
        forever
        begin
            @(posedge aclk);
            #2;
            fb_ready = 1'($urandom_range(0, 1));
        end
    endtask

    task automatic answer_swaps();
        forever
        begin
            @(posedge aclk);
            if (swap_fb && !fb_swapped)
            begin
                if (!rb_active || expect_lane != fb_pkg::LANE_COLOR
                    || beat_count != fb_pkg::TILE_PIXELS)
                begin
                    protocol_errors++;
                    $display("Swap requested at %0t without a finished color readback", $time);
                end
                repeat ($urandom_range(0, 6))
                    @(posedge aclk);
                #2;
                fb_swapped = 1'b1;
                @(posedge aclk);
                while (swap_fb)
                    @(posedge aclk);
                repeat ($urandom_range(0, 6))
                    @(posedge aclk);
                #2;
                fb_swapped = 1'b0;
                swap_count++;
            end
        end
    endtask

    always @(posedge aclk)
    begin
        if (rst_n && fb_valid && fb_ready)
        begin
            if (!rb_active || beat_count >= fb_pkg::TILE_PIXELS)
            begin
                protocol_errors++;
                $display("Pixel beat at %0t outside a readback or past the tile end", $time);
            end
            else
            begin
                check_pixel(model_tile[expect_lane][beat_count], fb_data,
                            fb_pkg::pixel_index_t'(beat_count));
                if (fb_last)
                begin
                    last_count++;
                    check_last(fb_pkg::pixel_index_t'(beat_count));
                end
            end
            beat_count++;
        end
    end

    initial
    begin
        fb_pkg::scissor_t  sc;
        fb_pkg::tile_x_t   x;
        fb_pkg::tile_y_t   y;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_data    = '0;
        fb_ready    = 1'b0;
        fb_swapped  = 1'b0;
        expect_lane = fb_pkg::LANE_COLOR;
        fork
            drive_ready();
            answer_swaps();
        join_none
        repeat (8)
            @(posedge aclk);
        #2;
        rst_n = 1'b1;

        // Full clear gives every pixel a known value
        set_scissor('0);
        for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
        begin
            set_config(fb_pkg::lane_sel_t'(l), 1'b1, 16'hffff);
            set_clear_value(fb_pkg::lane_sel_t'(l), fb_pkg::pixel_t'($urandom));
        end
        clear_lanes(3'b111);

        // Masked clears on all lanes
        for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
        begin
            set_config(fb_pkg::lane_sel_t'(l), 1'b1, fb_pkg::pixel_t'($urandom));
            set_clear_value(fb_pkg::lane_sel_t'(l), fb_pkg::pixel_t'($urandom));
        end
        clear_lanes(3'b111);
        for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
            read_lane(fb_pkg::lane_sel_t'(l));

        // Fragments with random enables and masks and words that must be ignored
        for (int r = 0; r < FRAG_ROUNDS; r++)
        begin
            for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
                set_config(fb_pkg::lane_sel_t'(l), $urandom_range(0, 3) != 0,
                           fb_pkg::pixel_t'($urandom));
            send_word({4'($urandom_range(7, 15)), 28'($urandom)});
            send_word({fb_pkg::OP_READBACK, 2'd3, 26'd0});
            for (int f = 0; f < FRAGS_PER_ROUND; f++)
                write_fragment(fb_pkg::tile_x_t'($urandom), fb_pkg::tile_y_t'($urandom),
                               4'($urandom), fb_pkg::pixel_t'($urandom),
                               fb_pkg::pixel_t'($urandom));
        end
        for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
            read_lane(fb_pkg::lane_sel_t'(l));

        // Scissored clears and fragments with half of them on the rectangle bounds
        for (int r = 0; r < SCISSOR_ROUNDS; r++)
        begin
            sc.enable  = 1'b1;
            sc.start_x = fb_pkg::tile_x_t'($urandom_range(0, 31));
            sc.end_x   = fb_pkg::tile_x_t'($urandom_range(sc.start_x, 31));
            sc.start_y = fb_pkg::tile_y_t'($urandom_range(0, 15));
            sc.end_y   = fb_pkg::tile_y_t'($urandom_range(sc.start_y, 15));
            set_scissor(sc);
            for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
            begin
                set_config(fb_pkg::lane_sel_t'(l), $urandom_range(0, 3) != 0,
                           fb_pkg::pixel_t'($urandom));
                set_clear_value(fb_pkg::lane_sel_t'(l), fb_pkg::pixel_t'($urandom));
            end
            clear_lanes(3'($urandom_range(1, 7)));
            for (int f = 0; f < SCISSOR_FRAGS; f++)
            begin
                x = fb_pkg::tile_x_t'($urandom);
                y = fb_pkg::tile_y_t'($urandom);
                if (f % 2 == 0)
                begin
                    x = $urandom_range(0, 1) ? sc.end_x + 5'($urandom_range(0, 1))
                                             : sc.start_x - 5'($urandom_range(0, 1));
                    y = $urandom_range(0, 1) ? sc.end_y + 4'($urandom_range(0, 1))
                                             : sc.start_y - 4'($urandom_range(0, 1));
                end
                write_fragment(x, y, 4'($urandom), fb_pkg::pixel_t'($urandom),
                               fb_pkg::pixel_t'($urandom));
            end
            for (int l = 0; l < fb_pkg::LANE_COUNT; l++)
                read_lane(fb_pkg::lane_sel_t'(l));
        end

        repeat (4)
            @(posedge aclk);
        $display(
            "Pixel errors %0d, last flag errors %0d, protocol errors %0d, assertion failures %0d",
            pixel_errors, last_errors, protocol_errors, UUT.checks.failures);
        if (pixel_errors + last_errors + protocol_errors + UUT.checks.failures == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
